// File: src/fp_pkg.sv
// Floating-point adder shared definitions
// Single-precision field widths, opcodes and result constants
package fp_pkg;

	// IEEE 754 single-precision fields
	localparam int EXPONENT_WIDTH = 8;
	localparam int SIGNIFICAND_WIDTH = 23;
	localparam int TOTAL_WIDTH = 1 + EXPONENT_WIDTH + SIGNIFICAND_WIDTH;

	// Internal significand
	// Stored fraction plus hidden bit, plus carry and sign headroom
	localparam int WORK_WIDTH = SIGNIFICAND_WIDTH + 3;

	// Alignment shift amount
	localparam int SHIFT_WIDTH = 6;

	// Larger differences shift everything out anyway
	localparam int MAX_ALIGN_SHIFT = (1 << SHIFT_WIDTH) - 1;

	// Operation select
	typedef enum logic
	{
		OP_FADD = 1'b0,
		OP_FSUB = 1'b1
	} fp_op_t;

	// Quiet NaN, every NaN result collapses to this
	localparam logic [TOTAL_WIDTH - 1:0] CANONICAL_NAN = 32'h7fc0_0000;

endpackage

// File: src/fp_adder_stage1.sv
// Floating-point adder, stage 1
// Unpacks both operands, computes the alignment shift, swaps so the larger
// exponent is first, converts significands to two's complement and flags inf/NaN
`timescale 1ns/1ps

module fp_adder_stage1
(
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   valid,
	input  fp_pkg::fp_op_t                         operation,
	input  logic [fp_pkg::TOTAL_WIDTH - 1:0]       operand1,
	input  logic [fp_pkg::TOTAL_WIDTH - 1:0]       operand2,
	output logic                                   add1_valid,
	output logic [fp_pkg::SHIFT_WIDTH - 1:0]       add1_operand_align_shift,
	output logic [fp_pkg::WORK_WIDTH - 1:0]        add1_significand1,
	output logic [fp_pkg::WORK_WIDTH - 1:0]        add1_significand2,
	output logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add1_exponent1,
	output logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add1_exponent2,
	output logic                                   add1_exponent2_larger,
	output logic                                   add1_result_is_inf,
	output logic                                   add1_result_is_nan,
	output logic                                   add1_inf_sign
);

	logic                                  sign1;
	logic                                  sign2;
	logic [fp_pkg::EXPONENT_WIDTH - 1:0]   exponent1;
	logic [fp_pkg::EXPONENT_WIDTH - 1:0]   exponent2;
	logic [fp_pkg::SIGNIFICAND_WIDTH - 1:0] fraction1;
	logic [fp_pkg::SIGNIFICAND_WIDTH - 1:0] fraction2;
	logic                                  subtract;
	logic                                  effective_sign2;
	logic [fp_pkg::EXPONENT_WIDTH:0]       exponent_difference;
	logic [fp_pkg::EXPONENT_WIDTH:0]       exponent_distance;
	logic                                  exponent2_larger;
	logic [fp_pkg::SHIFT_WIDTH - 1:0]      align_shift_nxt;
	logic [fp_pkg::WORK_WIDTH - 1:0]       unsigned_significand1;
	logic [fp_pkg::WORK_WIDTH - 1:0]       unsigned_significand2;
	logic [fp_pkg::WORK_WIDTH - 1:0]       twos_significand1;
	logic [fp_pkg::WORK_WIDTH - 1:0]       twos_significand2;
	logic                                  is_inf1;
	logic                                  is_inf2;
	logic                                  is_nan1;
	logic                                  is_nan2;
	logic                                  result_is_inf_nxt;
	logic                                  result_is_nan_nxt;
	logic                                  inf_sign_nxt;

	// Field extraction
	assign sign1 = operand1[fp_pkg::TOTAL_WIDTH - 1];
	assign sign2 = operand2[fp_pkg::TOTAL_WIDTH - 1];
	assign exponent1 = operand1[fp_pkg::TOTAL_WIDTH - 2:fp_pkg::SIGNIFICAND_WIDTH];
	assign exponent2 = operand2[fp_pkg::TOTAL_WIDTH - 2:fp_pkg::SIGNIFICAND_WIDTH];
	assign fraction1 = operand1[fp_pkg::SIGNIFICAND_WIDTH - 1:0];
	assign fraction2 = operand2[fp_pkg::SIGNIFICAND_WIDTH - 1:0];

	// Subtraction flips the sign of the second operand
	assign subtract = operation == fp_pkg::OP_FSUB;
	assign effective_sign2 = sign2 ^ subtract;

	// Exponent difference, top bit is the borrow
	assign exponent_difference = {1'b0, exponent1} - {1'b0, exponent2};
	assign exponent2_larger = exponent_difference[fp_pkg::EXPONENT_WIDTH];
	assign exponent_distance = exponent2_larger ? -exponent_difference : exponent_difference;

	// Saturate, anything past the work width shifts out completely
	assign align_shift_nxt = (exponent_distance > fp_pkg::MAX_ALIGN_SHIFT)
		? fp_pkg::SHIFT_WIDTH'(fp_pkg::MAX_ALIGN_SHIFT)
		: exponent_distance[fp_pkg::SHIFT_WIDTH - 1:0];

	// Hidden bit only for normal numbers
	assign unsigned_significand1 = {2'b00, exponent1 != '0, fraction1};
	assign unsigned_significand2 = {2'b00, exponent2 != '0, fraction2};

	// Two's complement conversion
	assign twos_significand1 = sign1 ? -unsigned_significand1 : unsigned_significand1;
	assign twos_significand2 = effective_sign2 ? -unsigned_significand2 : unsigned_significand2;

	// All-ones exponent, zero fraction is inf, otherwise NaN
	assign is_inf1 = (exponent1 == '1) && (fraction1 == '0);
	assign is_inf2 = (exponent2 == '1) && (fraction2 == '0);
	assign is_nan1 = (exponent1 == '1) && (fraction1 != '0);
	assign is_nan2 = (exponent2 == '1) && (fraction2 != '0);

	always_comb
	begin
		result_is_inf_nxt = 1'b0;
		result_is_nan_nxt = 1'b0;
		inf_sign_nxt = 1'b0;
		if (is_inf1 && is_inf2 && (sign1 != effective_sign2))
			// Opposing infinities
			result_is_nan_nxt = 1'b1;
		else if (is_inf1 || is_inf2)
		begin
			result_is_inf_nxt = 1'b1;
			// Operand 1 wins when both are infinite
			inf_sign_nxt = is_inf1 ? sign1 : effective_sign2;
		end
		else if (is_nan1 || is_nan2)
			result_is_nan_nxt = 1'b1;
	end

	// Valid travels every cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			add1_valid <= 1'b0;
		else
			add1_valid <= valid;
	end

	// Operand registers load only on an accepted input
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			add1_operand_align_shift <= '0;
			add1_significand1 <= '0;
			add1_significand2 <= '0;
			add1_exponent1 <= '0;
			add1_exponent2 <= '0;
			add1_exponent2_larger <= 1'b0;
			add1_result_is_inf <= 1'b0;
			add1_result_is_nan <= 1'b0;
			add1_inf_sign <= 1'b0;
		end
		else if (valid)
		begin
			add1_operand_align_shift <= align_shift_nxt;
			// Larger exponent goes to slot 1
			add1_significand1 <= exponent2_larger ? twos_significand2 : twos_significand1;
			add1_significand2 <= exponent2_larger ? twos_significand1 : twos_significand2;
			add1_exponent1 <= exponent1;
			add1_exponent2 <= exponent2;
			add1_exponent2_larger <= exponent2_larger;
			add1_result_is_inf <= result_is_inf_nxt;
			add1_result_is_nan <= result_is_nan_nxt;
			add1_inf_sign <= inf_sign_nxt;
		end
	end

endmodule

// File: src/fp_adder_stage2.sv
// Floating-point adder, stage 2
// Aligns the smaller significand with an arithmetic right shift and adds
`timescale 1ns/1ps

module fp_adder_stage2
(
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   add1_valid,
	input  logic [fp_pkg::SHIFT_WIDTH - 1:0]       add1_operand_align_shift,
	input  logic [fp_pkg::WORK_WIDTH - 1:0]        add1_significand1,
	input  logic [fp_pkg::WORK_WIDTH - 1:0]        add1_significand2,
	input  logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add1_exponent1,
	input  logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add1_exponent2,
	input  logic                                   add1_exponent2_larger,
	input  logic                                   add1_result_is_inf,
	input  logic                                   add1_result_is_nan,
	input  logic                                   add1_inf_sign,
	output logic                                   add2_valid,
	output logic [fp_pkg::WORK_WIDTH - 1:0]        add2_sum,
	output logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add2_exponent,
	output logic                                   add2_result_is_inf,
	output logic                                   add2_result_is_nan,
	output logic                                   add2_inf_sign
);

	logic signed [fp_pkg::WORK_WIDTH - 1:0] aligned_significand2;
	logic [fp_pkg::WORK_WIDTH - 1:0]        sum_nxt;

	// Sign fill, bits shifted past the LSB are lost
	assign aligned_significand2 = $signed(add1_significand2) >>> add1_operand_align_shift;

	// Headroom bits absorb carry-out and sign
	assign sum_nxt = add1_significand1 + aligned_significand2;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			add2_valid <= 1'b0;
		else
			add2_valid <= add1_valid;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			add2_sum <= '0;
			add2_exponent <= '0;
			add2_result_is_inf <= 1'b0;
			add2_result_is_nan <= 1'b0;
			add2_inf_sign <= 1'b0;
		end
		else if (add1_valid)
		begin
			add2_sum <= sum_nxt;
			// Result scale is that of the larger operand
			add2_exponent <= add1_exponent2_larger ? add1_exponent2 : add1_exponent1;
			add2_result_is_inf <= add1_result_is_inf;
			add2_result_is_nan <= add1_result_is_nan;
			add2_inf_sign <= add1_inf_sign;
		end
	end

endmodule

// File: src/fp_adder_stage3.sv
// Floating-point adder, stage 3
// Normalizes the sum with truncation, applies special cases and packs the result
`timescale 1ns/1ps

module fp_adder_stage3
(
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   add2_valid,
	input  logic [fp_pkg::WORK_WIDTH - 1:0]        add2_sum,
	input  logic [fp_pkg::EXPONENT_WIDTH - 1:0]    add2_exponent,
	input  logic                                   add2_result_is_inf,
	input  logic                                   add2_result_is_nan,
	input  logic                                   add2_inf_sign,
	output logic                                   result_valid,
	output logic [fp_pkg::TOTAL_WIDTH - 1:0]       result
);

	logic                                       sum_sign;
	logic [fp_pkg::WORK_WIDTH - 1:0]            magnitude;
	logic [$clog2(fp_pkg::WORK_WIDTH) - 1:0]    leading_one;
	logic [fp_pkg::WORK_WIDTH - 1:0]            normalized;
	logic signed [fp_pkg::EXPONENT_WIDTH + 1:0] exponent_adjusted;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]           result_nxt;

	// Sign and magnitude of the two's complement sum
	assign sum_sign = add2_sum[fp_pkg::WORK_WIDTH - 1];
	assign magnitude = sum_sign ? -add2_sum : add2_sum;

	// Leading one search, highest set bit wins
	always_comb
	begin
		leading_one = '0;
		for (int i = 0; i < fp_pkg::WORK_WIDTH - 1; i++)
		begin
			if (magnitude[i])
				leading_one = ($clog2(fp_pkg::WORK_WIDTH))'(i);
		end
	end

	// Move the leading one to the hidden bit position
	assign normalized = (leading_one > fp_pkg::SIGNIFICAND_WIDTH)
		? magnitude >> (leading_one - fp_pkg::SIGNIFICAND_WIDTH)
		: magnitude << (fp_pkg::SIGNIFICAND_WIDTH - leading_one);

	// Wide signed exponent so overflow and underflow stay visible
	assign exponent_adjusted = (fp_pkg::EXPONENT_WIDTH + 2)'(add2_exponent)
		+ (fp_pkg::EXPONENT_WIDTH + 2)'(leading_one)
		- (fp_pkg::EXPONENT_WIDTH + 2)'(fp_pkg::SIGNIFICAND_WIDTH);

	// Special cases by priority
	always_comb
	begin
		if (add2_result_is_nan)
			result_nxt = fp_pkg::CANONICAL_NAN;
		else if (add2_result_is_inf)
			result_nxt = {add2_inf_sign, {fp_pkg::EXPONENT_WIDTH{1'b1}},
				{fp_pkg::SIGNIFICAND_WIDTH{1'b0}}};
		else if (magnitude == '0)
			// Exact cancellation is positive zero
			result_nxt = '0;
		else if (exponent_adjusted >= $signed({2'b00, {fp_pkg::EXPONENT_WIDTH{1'b1}}}))
			// Overflow saturates
			result_nxt = {sum_sign, {fp_pkg::EXPONENT_WIDTH{1'b1}},
				{fp_pkg::SIGNIFICAND_WIDTH{1'b0}}};
		else if (exponent_adjusted <= 0)
			// No subnormal outputs, flush
			result_nxt = {sum_sign, {(fp_pkg::TOTAL_WIDTH - 1){1'b0}}};
		else
			result_nxt = {sum_sign, exponent_adjusted[fp_pkg::EXPONENT_WIDTH - 1:0],
				normalized[fp_pkg::SIGNIFICAND_WIDTH - 1:0]};
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			result_valid <= 1'b0;
		else
			result_valid <= add2_valid;
	end

	// Result holds between valid cycles
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			result <= '0;
		else if (add2_valid)
			result <= result_nxt;
	end

endmodule

// File: src/fp_adder.sv
// Single-precision floating-point adder/subtractor
// Three-stage pipeline, one operation per cycle, fixed latency of 3
`timescale 1ns/1ps

module fp_adder
(
	input  logic                                   clk,
	input  logic                                   reset_n,
	input  logic                                   valid,
	input  fp_pkg::fp_op_t                         operation,
	input  logic [fp_pkg::TOTAL_WIDTH - 1:0]       operand1,
	input  logic [fp_pkg::TOTAL_WIDTH - 1:0]       operand2,
	output logic                                   result_valid,
	output logic [fp_pkg::TOTAL_WIDTH - 1:0]       result
);

	// Stage 1 to stage 2
	logic                                add1_valid;
	logic [fp_pkg::SHIFT_WIDTH - 1:0]    add1_operand_align_shift;
	logic [fp_pkg::WORK_WIDTH - 1:0]     add1_significand1;
	logic [fp_pkg::WORK_WIDTH - 1:0]     add1_significand2;
	logic [fp_pkg::EXPONENT_WIDTH - 1:0] add1_exponent1;
	logic [fp_pkg::EXPONENT_WIDTH - 1:0] add1_exponent2;
	logic                                add1_exponent2_larger;
	logic                                add1_result_is_inf;
	logic                                add1_result_is_nan;
	logic                                add1_inf_sign;

	// Stage 2 to stage 3
	logic                                add2_valid;
	logic [fp_pkg::WORK_WIDTH - 1:0]     add2_sum;
	logic [fp_pkg::EXPONENT_WIDTH - 1:0] add2_exponent;
	logic                                add2_result_is_inf;
	logic                                add2_result_is_nan;
	logic                                add2_inf_sign;

	fp_adder_stage1 u_stage1
	(
		.clk                      (clk),
		.reset_n                  (reset_n),
		.valid                    (valid),
		.operation                (operation),
		.operand1                 (operand1),
		.operand2                 (operand2),
		.add1_valid               (add1_valid),
		.add1_operand_align_shift (add1_operand_align_shift),
		.add1_significand1        (add1_significand1),
		.add1_significand2        (add1_significand2),
		.add1_exponent1           (add1_exponent1),
		.add1_exponent2           (add1_exponent2),
		.add1_exponent2_larger    (add1_exponent2_larger),
		.add1_result_is_inf       (add1_result_is_inf),
		.add1_result_is_nan       (add1_result_is_nan),
		.add1_inf_sign            (add1_inf_sign)
	);

	fp_adder_stage2 u_stage2
	(
		.clk                      (clk),
		.reset_n                  (reset_n),
		.add1_valid               (add1_valid),
		.add1_operand_align_shift (add1_operand_align_shift),
		.add1_significand1        (add1_significand1),
		.add1_significand2        (add1_significand2),
		.add1_exponent1           (add1_exponent1),
		.add1_exponent2           (add1_exponent2),
		.add1_exponent2_larger    (add1_exponent2_larger),
		.add1_result_is_inf       (add1_result_is_inf),
		.add1_result_is_nan       (add1_result_is_nan),
		.add1_inf_sign            (add1_inf_sign),
		.add2_valid               (add2_valid),
		.add2_sum                 (add2_sum),
		.add2_exponent            (add2_exponent),
		.add2_result_is_inf       (add2_result_is_inf),
		.add2_result_is_nan       (add2_result_is_nan),
		.add2_inf_sign            (add2_inf_sign)
	);

	fp_adder_stage3 u_stage3
	(
		.clk                (clk),
		.reset_n            (reset_n),
		.add2_valid         (add2_valid),
		.add2_sum           (add2_sum),
		.add2_exponent      (add2_exponent),
		.add2_result_is_inf (add2_result_is_inf),
		.add2_result_is_nan (add2_result_is_nan),
		.add2_inf_sign      (add2_inf_sign),
		.result_valid       (result_valid),
		.result             (result)
	);

endmodule

// File: bench/fp_adder_assert.sv
// Protocol checks for the floating-point adder
// Fixed three-cycle latency, clean result strobe, result held between strobes
`timescale 1ns/1ps

module fp_adder_assert
(
	input logic                             clk,
	input logic                             reset_n,
	input logic                             valid,
	input logic                             result_valid,
	input logic [fp_pkg::TOTAL_WIDTH - 1:0] result
);

	// Every accepted input leaves exactly three edges later
	latency_check: assert property (@(posedge clk) disable iff (!reset_n)
		result_valid == $past(valid, 3))
	else
		$error("result_valid does not follow valid by three cycles");

	known_check: assert property (@(posedge clk) disable iff (!reset_n)
		!$isunknown(result_valid))
	else
		$error("result_valid is unknown");

	// Register only loads with a new result
	hold_check: assert property (@(posedge clk) disable iff (!reset_n)
		!result_valid |-> $stable(result))
	else
		$error("result changed without result_valid");

endmodule

bind fp_adder fp_adder_assert u_assert
(
	.clk          (clk),
	.reset_n      (reset_n),
	.valid        (valid),
	.result_valid (result_valid),
	.result       (result)
);

// File: bench/fp_adder_tb.sv
// Testbench for the floating-point adder
// Drives directed and LFSR-driven operations and checks them in order against a reference model
`timescale 1ns/1ps

module fp_adder_tb;

	localparam int TIMEOUT_CYCLES = 20;

	logic                                 clk;
	logic                                 reset_n;
	logic                                 valid;
	fp_pkg::fp_op_t                       operation;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     operand1;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     operand2;
	logic                                 result_valid;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     result;
	logic [31:0]                          lfsr_state;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     expected_q[$];
	// Opcode and both operands of each outstanding operation
	logic [2 * fp_pkg::TOTAL_WIDTH:0]     operands_q[$];
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     expected;
	logic [2 * fp_pkg::TOTAL_WIDTH:0]     operands;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     rand_a;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     rand_b;
	fp_pkg::fp_op_t                       special_op;
	logic [fp_pkg::TOTAL_WIDTH - 1:0]     sign_flip;
	int                                   stimulus_errors;
	int                                   compare_errors;
	int                                   accepted_count;
	int                                   result_count;
	bit                                   timed_out;

	fp_adder u_dut
	(
		.clk          (clk),
		.reset_n      (reset_n),
		.valid        (valid),
		.operation    (operation),
		.operand1     (operand1),
		.operand2     (operand2),
		.result_valid (result_valid),
		.result       (result)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	// Galois LFSR stepped once for every bit taken
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
		end
		return value;
	endfunction

	// Expected result from the pipeline's arithmetic rules
	function automatic logic [fp_pkg::TOTAL_WIDTH - 1:0] fp_add_model(input fp_pkg::fp_op_t op,
		input logic [31:0] a, input logic [31:0] b);
		int exp_a, exp_b;
		int mant_a, mant_b;
		int exp_big, gap;
		int value_big, value_small;
		int total, mag, top, exp_out;
		logic sign_a, sign_b, neg;
		logic [31:0] frac_out;
		sign_a = a[31];
		// Subtraction is addition of the negated second operand
		sign_b = b[31] ^ (op == fp_pkg::OP_FSUB);
		exp_a = int'(a[30:23]);
		exp_b = int'(b[30:23]);
		if (exp_a == 255 && exp_b == 255 && a[22:0] == 0 && b[22:0] == 0 && sign_a != sign_b)
			return fp_pkg::CANONICAL_NAN;
		if (exp_a == 255 && a[22:0] == 0)
			return {sign_a, 8'hff, 23'h0};
		if (exp_b == 255 && b[22:0] == 0)
			return {sign_b, 8'hff, 23'h0};
		if (exp_a == 255 || exp_b == 255)
			return fp_pkg::CANONICAL_NAN;
		// Signed significands with the hidden bit only for a nonzero exponent
		mant_a = int'(a[22:0]) + ((exp_a != 0) ? (1 << 23) : 0);
		mant_b = int'(b[22:0]) + ((exp_b != 0) ? (1 << 23) : 0);
		mant_a = sign_a ? -mant_a : mant_a;
		mant_b = sign_b ? -mant_b : mant_b;
		exp_big = (exp_b > exp_a) ? exp_b : exp_a;
		value_big = (exp_b > exp_a) ? mant_b : mant_a;
		value_small = (exp_b > exp_a) ? mant_a : mant_b;
		gap = (exp_b > exp_a) ? exp_b - exp_a : exp_a - exp_b;
		gap = (gap > fp_pkg::MAX_ALIGN_SHIFT) ? fp_pkg::MAX_ALIGN_SHIFT : gap;
		// Values stay below 2^24 so 31 already leaves only the sign
		gap = (gap > 31) ? 31 : gap;
		// Arithmetic shift rounds toward minus infinity
		total = value_big + (value_small >>> gap);
		neg = total < 0;
		mag = neg ? -total : total;
		if (mag == 0)
			return '0;
		top = 0;
		for (int i = 0; i < 31; i++)
		begin
			if (mag[i])
				top = i;
		end
		exp_out = exp_big + top - 23;
		if (exp_out >= 255)
			return {neg, 8'hff, 23'h0};
		if (exp_out <= 0)
			return {neg, 31'h0};
		frac_out = (top > 23) ? mag >> (top - 23) : mag << (23 - top);
		return {neg, exp_out[7:0], frac_out[22:0]};
	endfunction

	// Drives one accepted operation on the falling edge
	task automatic send_op(input fp_pkg::fp_op_t op, input logic [31:0] a, input logic [31:0] b);
		@(negedge clk);
		valid = 1'b1;
		operation = op;
		operand1 = a;
		operand2 = b;
		expected_q.push_back(fp_add_model(op, a, b));
		operands_q.push_back({op, a, b});
		accepted_count++;
	endtask

	// Drop valid and wait for every outstanding result
	task automatic drain(input string name);
		int waited;
		waited = 0;
		@(negedge clk);
		valid = 1'b0;
		while (expected_q.size() != 0 && waited < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() != 0)
		begin
			$display("%s: timed out with %0d results still missing", name, expected_q.size());
			timed_out = 1'b1;
		end
		$display("%s finished at %0t, errors so far %0d", name, $time,
			stimulus_errors + compare_errors);
	endtask

	// Results are stable on the falling edge
	always @(negedge clk)
	begin
		if (reset_n && result_valid)
		begin
			assert (expected_q.size() != 0)
			else
			begin
				$display("result %h arrived at %0t with no operation outstanding", result, $time);
				compare_errors++;
			end
			if (expected_q.size() != 0)
			begin
				expected = expected_q.pop_front();
				operands = operands_q.pop_front();
				result_count++;
				assert (result == expected)
				else
				begin
					$display("mismatch at %0t: op %0d a %h b %h expected %h actual %h", $time,
						operands[64], operands[63:32], operands[31:0], expected, result);
					compare_errors++;
				end
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		reset_n = 1'b0;
		valid = 1'b0;
		operation = fp_pkg::OP_FADD;
		operand1 = '0;
		operand2 = '0;
		lfsr_state = 32'h4498;
		stimulus_errors = 0;
		compare_errors = 0;
		accepted_count = 0;
		result_count = 0;
		timed_out = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		// Idle pipeline stays quiet
		repeat (5)
		begin
			@(negedge clk);
			assert (!result_valid && result == '0)
			else
			begin
				$display("mismatch at %0t: idle valid %b result %h", $time, result_valid, result);
				stimulus_errors++;
			end
		end
		$display("reset_idle finished at %0t, errors so far %0d", $time, stimulus_errors);

		// Known anchors for the model itself
		assert (fp_add_model(fp_pkg::OP_FADD, 32'h3f80_0000, 32'h3f80_0000) == 32'h4000_0000
			&& fp_add_model(fp_pkg::OP_FSUB, 32'h4040_0000, 32'h3f80_0000) == 32'h4000_0000
			&& fp_add_model(fp_pkg::OP_FADD, 32'h3fc0_0000, 32'hbfc0_0000) == 32'h0000_0000)
		else
		begin
			$display("mismatch at %0t: reference model fails the known sums", $time);
			stimulus_errors++;
		end
		send_op(fp_pkg::OP_FADD, 32'h3f80_0000, 32'h3f80_0000);
		send_op(fp_pkg::OP_FSUB, 32'h4040_0000, 32'h3f80_0000);
		send_op(fp_pkg::OP_FADD, 32'h3fc0_0000, 32'hbfc0_0000);
		send_op(fp_pkg::OP_FSUB, 32'hc0a0_0000, 32'h4040_0000);
		send_op(fp_pkg::OP_FADD, 32'h3fff_ffff, 32'h3fff_ffff);
		send_op(fp_pkg::OP_FSUB, 32'h3f80_0001, 32'h3f7f_ffff);
		drain("directed");

		// Alignment at and past the shift limit
		send_op(fp_pkg::OP_FADD, 32'h5f00_0000, 32'h3f80_0000);
		// A gap of 64 only shifts out when the shift saturates
		send_op(fp_pkg::OP_FADD, 32'h5f80_0000, 32'hbf80_0000);
		send_op(fp_pkg::OP_FADD, 32'h7e80_0000, 32'h3f80_0000);
		send_op(fp_pkg::OP_FADD, 32'h7e80_0000, 32'hbf80_0000);
		send_op(fp_pkg::OP_FSUB, 32'h3f80_0000, 32'h7e80_0000);
		send_op(fp_pkg::OP_FADD, 32'h3f80_0000, 32'h0000_0001);
		drain("large_shift");

		for (int k = 0; k < 2; k++)
		begin
			special_op = (k == 1) ? fp_pkg::OP_FSUB : fp_pkg::OP_FADD;
			sign_flip = (k == 1) ? 32'h8000_0000 : 32'h0000_0000;
			send_op(special_op, 32'h7f80_0000, 32'h3f80_0000);
			send_op(special_op, 32'h3f80_0000, 32'hff80_0000);
			send_op(special_op, 32'h7f80_0000, 32'h7f80_0000);
			send_op(special_op, 32'h7f80_0000, 32'hff80_0000);
			send_op(special_op, 32'h7f80_0001, 32'h3f80_0000);
			send_op(special_op, 32'h3f80_0000, 32'hffc0_0000);
			// Overflow and near-cancellation below the normal range
			// Second sign follows the opcode so both opcodes reach them
			send_op(special_op, 32'h7f7f_ffff, 32'h7f7f_ffff ^ sign_flip);
			send_op(special_op, 32'h0080_0001, 32'h8080_0000 ^ sign_flip);
			send_op(special_op, 32'h8080_0001, 32'h0080_0000 ^ sign_flip);
		end
		drain("special_cases");

		repeat (500)
		begin
			rand_a = random_bits(32);
			rand_b = random_bits(32);
			// Nearby exponents exercise real alignment
			if (random_bits(1) != 0)
				rand_b[30:23] = rand_a[30:23] ^ 8'(random_bits(3));
			send_op((random_bits(1) != 0) ? fp_pkg::OP_FSUB : fp_pkg::OP_FADD, rand_a, rand_b);
			if (random_bits(2) == 0)
			begin
				@(negedge clk);
				valid = 1'b0;
			end
		end
		drain("random_stream");
		assert (result_count == accepted_count)
		else
		begin
			$display("mismatch at %0t: got %0d results for %0d accepted operations", $time,
				result_count, accepted_count);
			stimulus_errors++;
		end

		$display("tests 5, accepted %0d, results %0d, errors %0d", accepted_count, result_count,
			stimulus_errors + compare_errors);
		if (stimulus_errors == 0 && compare_errors == 0 && !timed_out)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: fp_adder.f
src/fp_pkg.sv
src/fp_adder_stage1.sv
src/fp_adder_stage2.sv
src/fp_adder_stage3.sv
src/fp_adder.sv
bench/fp_adder_assert.sv
bench/fp_adder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the floating-point adder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fp_adder_tb \
	-f fp_adder.f --Mdir obj_dir -o fp_adder_sim > build.log 2>&1 \
	&& ./obj_dir/fp_adder_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
! grep -qF '*** FAILED ***' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation reported failure"; exit 1; }
